// ==== rtl/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Reorder buffer entries, power of two
`define OOO_ROB_DEPTH 16

// Multiplier pipeline stages
`define OOO_MUL_LAT 3

// Divider iterations, one per quotient bit
`define OOO_DIV_CYCLES 32

`endif

// ==== rtl/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;  // Buffer entry index
    typedef logic [31:0] xlen_t;                            // Data word
    typedef logic [4:0]  reg_idx_t;                         // Architectural register

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,  // Illegal, needs no unit
        UNIT_ALU  = 2'd1,
        UNIT_MUL  = 2'd2,
        UNIT_DIV  = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        OP_ADD      = 4'd0,
        OP_SUB      = 4'd1,
        OP_AND      = 4'd2,
        OP_OR       = 4'd3,
        OP_XOR      = 4'd4,
        OP_SLL      = 4'd5,
        OP_SRL      = 4'd6,
        OP_SLT      = 4'd7,
        OP_SLTU     = 4'd8,
        OP_DIV_QUOT = 4'd9,   // Divider returns quotient
        OP_DIV_REM  = 4'd10   // Divider returns remainder
    } alu_op_e;

    // Instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

    localparam logic [6:0] OP_REG = 7'b0110011;  // R-type opcode

endpackage

// ==== rtl/issue_if.sv ====
interface issue_if;
    import ooo_pkg::*;

    logic     valid;  // One-cycle issue strobe
    rob_tag_t tag;    // Entry the result goes to
    alu_op_e  op;     // Operation select
    xlen_t    src_a;  // rs1 operand
    xlen_t    src_b;  // rs2 operand

    modport source (
        output valid,
        output tag,
        output op,
        output src_a,
        output src_b
    );

    modport sink (
        input valid,
        input tag,
        input op,
        input src_a,
        input src_b
    );

endinterface

// ==== rtl/issue_decode.sv ====
module issue_decode (
    input  logic              inst_valid,
    input  ooo_pkg::xlen_t    inst,
    input  ooo_pkg::xlen_t    rs1_value,
    input  ooo_pkg::xlen_t    rs2_value,
    input  logic              rob_full,
    input  logic              div_busy,
    input  ooo_pkg::rob_tag_t alloc_tag,
    output logic              inst_stall,
    output logic              alloc_valid,
    output ooo_pkg::reg_idx_t alloc_dest,
    output logic              alloc_reg_write,
    output logic              alloc_done,
    issue_if.source           alu_issue,
    issue_if.source           mul_issue,
    issue_if.source           div_issue
);
    import ooo_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    unit_e      unit_sel;
    alu_op_e    op_sel;
    logic       accept;

    assign opcode = inst[OPCODE_MSB:OPCODE_LSB];
    assign funct3 = inst[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = inst[FUNCT7_MSB:FUNCT7_LSB];

    always_comb begin
        unit_sel = UNIT_NONE;  // Anything unmatched is illegal
        op_sel   = OP_ADD;
        if (opcode == OP_REG) begin
            case (funct7)
                7'b0000000: begin
                    unit_sel = UNIT_ALU;
                    case (funct3)
                        3'b000:  op_sel = OP_ADD;
                        3'b001:  op_sel = OP_SLL;
                        3'b010:  op_sel = OP_SLT;
                        3'b011:  op_sel = OP_SLTU;
                        3'b100:  op_sel = OP_XOR;
                        3'b101:  op_sel = OP_SRL;
                        3'b110:  op_sel = OP_OR;
                        default: op_sel = OP_AND;
                    endcase
                end
                7'b0100000: begin
                    if (funct3 == 3'b000) begin  // sra not supported
                        unit_sel = UNIT_ALU;
                        op_sel   = OP_SUB;
                    end
                end
                7'b0000001: begin
                    case (funct3)
                        3'b000: unit_sel = UNIT_MUL;  // mul, low word
                        3'b101: begin                  // divu
                            unit_sel = UNIT_DIV;
                            op_sel   = OP_DIV_QUOT;
                        end
                        3'b111: begin                  // remu
                            unit_sel = UNIT_DIV;
                            op_sel   = OP_DIV_REM;
                        end
                        default: unit_sel = UNIT_NONE; // mulh and signed div
                    endcase
                end
                default: unit_sel = UNIT_NONE;
            endcase
        end
    end

    // Single stall point for the whole stage
    assign inst_stall = rob_full || ((unit_sel == UNIT_DIV) && div_busy);
    assign accept     = inst_valid && !inst_stall;

    assign alloc_valid     = accept;
    assign alloc_dest      = inst[RD_MSB:RD_LSB];
    assign alloc_reg_write = (alloc_dest != '0) && (unit_sel != UNIT_NONE);  // x0 never written
    assign alloc_done      = (unit_sel == UNIT_NONE);  // Illegal entry is ready at once

    assign alu_issue.valid = accept && (unit_sel == UNIT_ALU);
    assign alu_issue.tag   = alloc_tag;
    assign alu_issue.op    = op_sel;
    assign alu_issue.src_a = rs1_value;
    assign alu_issue.src_b = rs2_value;

    assign mul_issue.valid = accept && (unit_sel == UNIT_MUL);
    assign mul_issue.tag   = alloc_tag;
    assign mul_issue.op    = op_sel;
    assign mul_issue.src_a = rs1_value;
    assign mul_issue.src_b = rs2_value;

    assign div_issue.valid = accept && (unit_sel == UNIT_DIV);
    assign div_issue.tag   = alloc_tag;
    assign div_issue.op    = op_sel;
    assign div_issue.src_a = rs1_value;  // Dividend
    assign div_issue.src_b = rs2_value;  // Divisor

endmodule

// ==== rtl/alu_unit.sv ====
module alu_unit (
    input  logic              clk,
    input  logic              rst,
    issue_if.sink             issue,
    output logic              done,
    output ooo_pkg::rob_tag_t done_tag,
    output ooo_pkg::xlen_t    done_value
);
    import ooo_pkg::*;

    xlen_t result;

    always_comb begin
        case (issue.op)
            OP_ADD:  result = issue.src_a + issue.src_b;
            OP_SUB:  result = issue.src_a - issue.src_b;
            OP_AND:  result = issue.src_a & issue.src_b;
            OP_OR:   result = issue.src_a | issue.src_b;
            OP_XOR:  result = issue.src_a ^ issue.src_b;
            OP_SLL:  result = issue.src_a << issue.src_b[4:0];  // Low five bits only
            OP_SRL:  result = issue.src_a >> issue.src_b[4:0];
            OP_SLT:  result = {31'd0, $signed(issue.src_a) < $signed(issue.src_b)};
            OP_SLTU: result = {31'd0, issue.src_a < issue.src_b};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= issue.valid;  // Result one cycle after issue
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            done_tag   <= issue.tag;
            done_value <= result;
        end
    end

endmodule

// ==== rtl/mul_unit.sv ====
`include "ooo_settings.svh"

module mul_unit (
    input  logic              clk,
    input  logic              rst,
    issue_if.sink             issue,
    output logic              done,
    output ooo_pkg::rob_tag_t done_tag,
    output ooo_pkg::xlen_t    done_value
);
    import ooo_pkg::*;

    localparam int LAT = `OOO_MUL_LAT;

    logic     valid_q [LAT];  // Stage occupancy
    rob_tag_t tag_q   [LAT];  // Tag rides with product
    xlen_t    prod_q  [LAT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LAT; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= issue.valid;
            for (int i = 1; i < LAT; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= issue.tag;
        prod_q[0] <= issue.src_a * issue.src_b;  // Low word kept, first stage
        for (int i = 1; i < LAT; i++) begin
            tag_q[i]  <= tag_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign done       = valid_q[LAT-1];
    assign done_tag   = tag_q[LAT-1];
    assign done_value = prod_q[LAT-1];

endmodule

// ==== rtl/div_unit.sv ====
`include "ooo_settings.svh"

module div_unit (
    input  logic              clk,
    input  logic              rst,
    issue_if.sink             issue,
    output logic              done,
    output ooo_pkg::rob_tag_t done_tag,
    output ooo_pkg::xlen_t    done_value,
    output logic              busy
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(`OOO_DIV_CYCLES + 1);

    logic [CNT_W-1:0] count_q;    // Iterations left
    rob_tag_t         tag_q;
    logic             rem_sel_q;  // Return remainder, not quotient
    xlen_t            quot_q;     // Dividend shifts out, quotient shifts in
    xlen_t            rem_q;
    xlen_t            divisor_q;
    logic [32:0]      rem_shift;
    logic [32:0]      diff;

    assign rem_shift = {rem_q, quot_q[31]};
    assign diff      = rem_shift - {1'b0, divisor_q};  // Top bit set on borrow

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            count_q <= '0;
        end else begin
            done <= busy && (count_q == CNT_W'(1));  // Last iteration this edge
            if (issue.valid) begin
                busy    <= 1'b1;
                count_q <= CNT_W'(`OOO_DIV_CYCLES);
            end else if (busy) begin
                count_q <= count_q - 1'b1;
                if (count_q == CNT_W'(1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Zero divisor never borrows, so quotient ends all ones and remainder is the dividend
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            tag_q     <= issue.tag;
            rem_sel_q <= (issue.op == OP_DIV_REM);
            quot_q    <= issue.src_a;
            rem_q     <= '0;
            divisor_q <= issue.src_b;
        end else if (busy) begin
            if (!diff[32]) begin
                rem_q  <= diff[31:0];  // Subtract fits
                quot_q <= {quot_q[30:0], 1'b1};
            end else begin
                rem_q  <= rem_shift[31:0];  // Restore
                quot_q <= {quot_q[30:0], 1'b0};
            end
        end
    end

    assign done_tag   = tag_q;
    assign done_value = rem_sel_q ? rem_q : quot_q;

endmodule

// ==== rtl/reorder_buffer.sv ====
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_valid,
    input  ooo_pkg::reg_idx_t alloc_dest,
    input  logic              alloc_reg_write,
    input  logic              alloc_done,
    output ooo_pkg::rob_tag_t alloc_tag,
    output logic              rob_full,
    input  logic              alu_done,
    input  ooo_pkg::rob_tag_t alu_tag,
    input  ooo_pkg::xlen_t    alu_value,
    input  logic              mul_done,
    input  ooo_pkg::rob_tag_t mul_tag,
    input  ooo_pkg::xlen_t    mul_value,
    input  logic              div_done,
    input  ooo_pkg::rob_tag_t div_tag,
    input  ooo_pkg::xlen_t    div_value,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_dest,
    output ooo_pkg::xlen_t    commit_value,
    output logic              commit_reg_write
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             ready_q [DEPTH];  // Result present
    logic             wen_q   [DEPTH];
    reg_idx_t         dest_q  [DEPTH];
    xlen_t            value_q [DEPTH];
    rob_tag_t         head_q;           // Oldest entry
    rob_tag_t         tail_q;           // Next free entry
    logic [CNT_W-1:0] count_q;
    logic             alloc;
    logic             retire;

    assign rob_full  = (count_q == CNT_W'(DEPTH));
    assign alloc_tag = tail_q;  // Tag is the slot index
    assign alloc     = alloc_valid && !rob_full;
    assign retire    = (count_q != '0) && ready_q[head_q];  // In order only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                ready_q[i] <= 1'b0;
                wen_q[i]   <= 1'b0;
                dest_q[i]  <= '0;
                value_q[i] <= '0;
            end
        end else begin
            if (retire) begin
                ready_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;  // Wraps at depth
            end
            if (alloc) begin
                ready_q[tail_q] <= alloc_done;
                wen_q[tail_q]   <= alloc_reg_write;
                dest_q[tail_q]  <= alloc_dest;
                value_q[tail_q] <= '0;
                tail_q          <= tail_q + 1'b1;
            end
            // Three write ports, tags always distinct
            if (alu_done) begin
                value_q[alu_tag] <= alu_value;
                ready_q[alu_tag] <= 1'b1;
            end
            if (mul_done) begin
                value_q[mul_tag] <= mul_value;
                ready_q[mul_tag] <= 1'b1;
            end
            if (div_done) begin
                value_q[div_tag] <= div_value;
                ready_q[div_tag] <= 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid     <= 1'b0;
            commit_reg_write <= 1'b0;
            commit_dest      <= '0;
            commit_value     <= '0;
        end else begin
            commit_valid     <= retire;  // One pulse per entry
            commit_reg_write <= retire && wen_q[head_q];
            if (retire) begin
                commit_dest  <= dest_q[head_q];
                commit_value <= value_q[head_q];
            end
        end
    end

endmodule

// ==== rtl/ooo_core_top.sv ====
module ooo_core_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  ooo_pkg::xlen_t    inst,
    input  ooo_pkg::xlen_t    rs1_value,
    input  ooo_pkg::xlen_t    rs2_value,
    output logic              inst_stall,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_dest,
    output ooo_pkg::xlen_t    commit_value,
    output logic              commit_reg_write
);
    import ooo_pkg::*;

    logic     rob_full;
    logic     div_busy;
    logic     alloc_valid;
    reg_idx_t alloc_dest;
    logic     alloc_reg_write;
    logic     alloc_done;
    rob_tag_t alloc_tag;
    logic     alu_done;
    rob_tag_t alu_tag;
    xlen_t    alu_value;
    logic     mul_done;
    rob_tag_t mul_tag;
    xlen_t    mul_value;
    logic     div_done;
    rob_tag_t div_tag;
    xlen_t    div_value;

    issue_if alu_issue ();  // Decode to ALU
    issue_if mul_issue ();  // Decode to multiplier
    issue_if div_issue ();  // Decode to divider

    issue_decode i_decode (
        .inst_valid      (inst_valid),
        .inst            (inst),
        .rs1_value       (rs1_value),
        .rs2_value       (rs2_value),
        .rob_full        (rob_full),
        .div_busy        (div_busy),
        .alloc_tag       (alloc_tag),
        .inst_stall      (inst_stall),
        .alloc_valid     (alloc_valid),
        .alloc_dest      (alloc_dest),
        .alloc_reg_write (alloc_reg_write),
        .alloc_done      (alloc_done),
        .alu_issue       (alu_issue.source),
        .mul_issue       (mul_issue.source),
        .div_issue       (div_issue.source)
    );

    alu_unit i_alu (
        .clk        (clk),
        .rst        (rst),
        .issue      (alu_issue.sink),
        .done       (alu_done),
        .done_tag   (alu_tag),
        .done_value (alu_value)
    );

    mul_unit i_mul (
        .clk        (clk),
        .rst        (rst),
        .issue      (mul_issue.sink),
        .done       (mul_done),
        .done_tag   (mul_tag),
        .done_value (mul_value)
    );

    div_unit i_div (
        .clk        (clk),
        .rst        (rst),
        .issue      (div_issue.sink),
        .done       (div_done),
        .done_tag   (div_tag),
        .done_value (div_value),
        .busy       (div_busy)
    );

    reorder_buffer i_rob (
        .clk              (clk),
        .rst              (rst),
        .alloc_valid      (alloc_valid),
        .alloc_dest       (alloc_dest),
        .alloc_reg_write  (alloc_reg_write),
        .alloc_done       (alloc_done),
        .alloc_tag        (alloc_tag),
        .rob_full         (rob_full),
        .alu_done         (alu_done),
        .alu_tag          (alu_tag),
        .alu_value        (alu_value),
        .mul_done         (mul_done),
        .mul_tag          (mul_tag),
        .mul_value        (mul_value),
        .div_done         (div_done),
        .div_tag          (div_tag),
        .div_value        (div_value),
        .commit_valid     (commit_valid),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write)
    );

endmodule

// ==== verif/ooo_core_tb.sv ====
`include "ooo_settings.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int HALF        = 20;   // Half clock period
    localparam int STALL_LIMIT = 200;  // Cycles one instruction may stall
    localparam int DRAIN_LIMIT = 600;  // Cycles to empty the buffer

    typedef struct packed {
        logic     legal;  // Value checked only for legal ops
        logic     wen;
        reg_idx_t dest;
        xlen_t    value;
    } exp_t;

    logic     clk;
    logic     rst;
    logic     inst_valid;
    xlen_t    inst;
    xlen_t    rs1_value;
    xlen_t    rs2_value;
    logic     inst_stall;
    logic     commit_valid;
    reg_idx_t commit_dest;
    xlen_t    commit_value;
    logic     commit_reg_write;

    exp_t exp_q[$];         // Program order expectations
    exp_t head_exp;
    int   accepted     = 0; // Handshakes seen on the DUT pins
    int   commit_count = 0;
    int   stall_cycles = 0; // Cycles seen with inst_stall high

    ooo_core_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .rs1_value        (rs1_value),
        .rs2_value        (rs2_value),
        .inst_stall       (inst_stall),
        .commit_valid     (commit_valid),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write)
    );

    always #HALF clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Expected commit from the R-type rules
    function automatic exp_t ref_result(input xlen_t i, input xlen_t a, input xlen_t b);
        exp_t       e;
        logic [9:0] f;
        f       = {i[31:25], i[14:12]};  // funct7 then funct3
        e.dest  = i[11:7];
        e.legal = 1'b1;
        e.value = '0;
        if (i[6:0] != 7'b0110011) begin
            e.legal = 1'b0;
        end else begin
            case (f)
                10'b0000000_000: e.value = a + b;
                10'b0100000_000: e.value = a - b;
                10'b0000000_001: e.value = a << b[4:0];
                10'b0000000_010: e.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                10'b0000000_011: e.value = (a < b) ? 32'd1 : 32'd0;
                10'b0000000_100: e.value = a ^ b;
                10'b0000000_101: e.value = a >> b[4:0];
                10'b0000000_110: e.value = a | b;
                10'b0000000_111: e.value = a & b;
                10'b0000001_000: e.value = a * b;                    // Low word
                10'b0000001_101: e.value = (b == 0) ? '1 : a / b;    // divu
                10'b0000001_111: e.value = (b == 0) ? a : a % b;     // remu
                default:         e.legal = 1'b0;
            endcase
        end
        e.wen = e.legal && (e.dest != 5'd0);
        return e;
    endfunction

    // Kind 0 ALU, 1 mul, 2 div or rem, 3 illegal
    function automatic xlen_t build_inst(input int kind);
        logic [6:0] f7;
        logic [2:0] f3;
        logic [6:0] op;
        logic [4:0] rd;
        int         sel;
        op  = 7'b0110011;
        rd  = ($urandom_range(0, 5) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
        sel = $urandom_range(0, 8);
        case (kind)
            0: begin
                f7 = (sel == 8) ? 7'b0100000 : 7'b0000000;  // Eight base ops plus sub
                f3 = (sel == 8) ? 3'b000 : 3'(sel);
            end
            1: begin
                f7 = 7'b0000001;
                f3 = 3'b000;
            end
            2: begin
                f7 = 7'b0000001;
                f3 = sel[0] ? 3'b101 : 3'b111;
            end
            default: begin
                f7 = (sel < 3) ? 7'b0000001 : 7'b0100000;  // mulh or sra
                f3 = (sel < 3) ? 3'b001 : 3'b101;
                if (sel > 5) begin
                    op = 7'b0010011;  // Immediate opcode
                end
            end
        endcase
        return {f7, 5'($urandom), 5'($urandom), f3, rd, op};
    endfunction

    // Hold the instruction from a falling edge until accepted
    task automatic send(input xlen_t i, input xlen_t a, input xlen_t b);
        int waited;
        waited = 0;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = i;
        rs1_value  = a;
        rs2_value  = b;
        #(HALF / 2);
        while (inst_stall) begin
            stall_cycles++;
            waited++;
            if (waited > STALL_LIMIT) begin
                report_failure("Instruction stalled too long and was never accepted");
            end
            @(negedge clk);
            #(HALF / 2);
        end
        exp_q.push_back(ref_result(i, a, b));
        @(posedge clk);  // Accept edge
    endtask

    task automatic send_random(input int kind);
        xlen_t b;
        b = $urandom_range(0, 1) ? $urandom : 32'($urandom_range(0, 999));
        if (kind == 2 && $urandom_range(0, 4) == 0) begin
            b = '0;  // Divide by zero
        end
        send(build_inst(kind), $urandom, b);
    endtask

    task automatic idle();
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                report_failure("Outstanding instructions never committed");
            end
        end
    endtask

    task automatic check_low(input string name, input logic v);
        assert (v == 1'b0)
            else report_failure($sformatf("FAIL t=%0t %s expected 0 got %b", $time, name, v));
    endtask

    // Accept edges counted from the DUT handshake
    always @(posedge clk) begin
        if (!rst && inst_valid && !inst_stall) begin
            accepted++;
        end
    end

    // Scoreboard pops one expectation per commit pulse
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            assert (exp_q.size() > 0)
                else report_failure("Commit seen with no instruction outstanding");
            head_exp = exp_q.pop_front();
            commit_count++;
            assert (commit_dest == head_exp.dest)
                else report_failure($sformatf("FAIL t=%0t commit_dest expected %0d got %0d",
                                              $time, head_exp.dest, commit_dest));
            assert (commit_reg_write == head_exp.wen)
                else report_failure($sformatf("FAIL t=%0t commit_reg_write expected %b got %b",
                                              $time, head_exp.wen, commit_reg_write));
            if (head_exp.legal) begin
                assert (commit_value == head_exp.value)
                    else report_failure($sformatf("FAIL t=%0t commit_value expected %h got %h",
                                                  $time, head_exp.value, commit_value));
            end
        end
    end

    initial begin
        void'($urandom(53));
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_value  = '0;
        rs2_value  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);  // Quiet outputs after reset
        check_low("commit_valid", commit_valid);
        check_low("commit_reg_write", commit_reg_write);
        check_low("inst_stall", inst_stall);

        for (int n = 0; n < 40; n++) begin
            send_random(0);
        end
        idle();
        drain();

        for (int n = 0; n < 60; n++) begin
            send_random($urandom_range(0, 2));  // Slow and fast ops interleaved
        end
        idle();
        drain();

        for (int n = 0; n < 40; n++) begin
            send_random($urandom_range(0, 3));
        end
        idle();
        drain();

        stall_cycles = 0;
        for (int n = 0; n < 3; n++) begin
            send_random(2);
        end
        idle();
        assert (stall_cycles > 0)
            else report_failure("Back-to-back divides never raised inst_stall");
        drain();

        stall_cycles = 0;
        send_random(2);  // Blocks the head while the buffer fills
        for (int n = 0; n < `OOO_ROB_DEPTH + 8; n++) begin
            send_random(0);
        end
        idle();
        assert (stall_cycles > 0)
            else report_failure("Burst behind a divide never raised inst_stall");
        drain();

        repeat (10) @(posedge clk);  // Catch stray commits
        assert (exp_q.size() == 0)
            else report_failure("Expectations left after the run");
        assert (commit_count == accepted)
            else report_failure($sformatf("FAIL t=%0t commit_count expected %0d got %0d",
                                          $time, accepted, commit_count));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/ooo_pkg.sv
rtl/issue_if.sv
rtl/issue_decode.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core_top.sv
verif/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

export_include_dirs:
  - rtl

sources:
  - rtl/ooo_pkg.sv
  - rtl/issue_if.sv
  - rtl/issue_decode.sv
  - rtl/alu_unit.sv
  - rtl/mul_unit.sv
  - rtl/div_unit.sv
  - rtl/reorder_buffer.sv
  - rtl/ooo_core_top.sv
  - target: test
    files:
      - verif/ooo_core_tb.sv
